// File: hdl/uart_cmd_pkg.sv
package uart_cmd_pkg;

  // bit timing, 115200 baud from a 50 MHz clock
  localparam int CLKS_PER_BIT = 434;
  localparam int HALF_BIT     = CLKS_PER_BIT / 2;

  // command word layout
  localparam int CMD_W      = 16;
  localparam int CMD_RW_BIT = 15;

  typedef logic [CMD_W-1:0] cmd_t;
  typedef logic [7:0]       byte_t;

  // must hold CLKS_PER_BIT - 1
  typedef logic [8:0]       baud_cnt_t;

  // position inside a frame
  typedef logic [3:0]       bit_idx_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_HI,
    SEQ_LO
  } seq_state_t;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP
  } tx_state_t;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_t;

endpackage

// File: hdl/baud_tick.sv
module baud_tick (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  output logic bit_end,
  output logic mid_bit
);

  import uart_cmd_pkg::*;

  baud_cnt_t cnt;
  logic      at_last;

  assign at_last = (cnt == baud_cnt_t'(CLKS_PER_BIT - 1));

  // held at zero while idle so the first bit starts clean
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (!run) begin
      cnt <= '0;
    end else if (at_last) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + baud_cnt_t'(1);
    end
  end

  assign bit_end = run && at_last;
  assign mid_bit = run && (cnt == baud_cnt_t'(HALF_BIT));

endmodule

// File: hdl/uart_tx_frame.sv
module uart_tx_frame (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_cmd_pkg::byte_t  frame_byte,
  input  logic                 frame_start,
  output logic                 frame_done,
  output logic                 tx
);

  import uart_cmd_pkg::*;

  tx_state_t state;
  bit_idx_t  bit_idx;
  byte_t     shift;
  logic      par;
  logic      run;
  logic      bit_end;
  logic      load;

  assign run = (state != TX_IDLE);

  // only the bit-end strobe is needed on the transmit side
  baud_tick u_baud (
    .clk     (clk),
    .rst_n   (rst_n),
    .run     (run),
    .bit_end (bit_end),
    .mid_bit ()
  );

  assign frame_done = (state == TX_STOP) && bit_end;

  // new byte either from idle or straight after a stop bit
  assign load = frame_start && ((state == TX_IDLE) || frame_done);

  always_ff @(posedge clk) begin
    if (load) begin
      shift <= frame_byte;
      par   <= ~^frame_byte;
    end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
      shift <= {shift[6:0], 1'b0};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= TX_IDLE;
      bit_idx <= '0;
      tx      <= 1'b1;
    end else begin
      unique case (state)
        TX_IDLE: begin
          if (load) begin
            state <= TX_START;
            tx    <= 1'b0;
          end
        end
        TX_START: begin
          if (bit_end) begin
            state   <= TX_DATA;
            bit_idx <= '0;
            tx      <= shift[7];
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            if (bit_idx == bit_idx_t'(7)) begin
              state <= TX_PARITY;
              tx    <= par;
            end else begin
              bit_idx <= bit_idx + bit_idx_t'(1);
              tx      <= shift[7];
            end
          end
        end
        TX_PARITY: begin
          if (bit_end) begin
            state <= TX_STOP;
            tx    <= 1'b1;
          end
        end
        TX_STOP: begin
          if (load) begin
            state <= TX_START;
            tx    <= 1'b0;
          end else if (bit_end) begin
            state <= TX_IDLE;
          end
        end
        default: begin
          state <= TX_IDLE;
          tx    <= 1'b1;
        end
      endcase
    end
  end

endmodule

// File: hdl/cmd_sequencer.sv
module cmd_sequencer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_cmd_pkg::cmd_t   cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output uart_cmd_pkg::byte_t  frame_byte,
  output logic                 frame_start,
  input  logic                 frame_done
);

  import uart_cmd_pkg::*;

  seq_state_t state;
  byte_t      lo_byte;
  logic       two_byte;
  logic       accept;
  logic       hi_done;

  assign cmd_rdy = (state == SEQ_IDLE);
  assign accept  = cmd_vld && cmd_rdy;
  assign hi_done = (state == SEQ_HI) && frame_done;

  // high byte goes out in the accept cycle, low byte at the end of the first frame
  assign frame_start = accept || (hi_done && two_byte);
  assign frame_byte  = (state == SEQ_IDLE) ? cmd_in[CMD_W-1 -: 8] : lo_byte;

  // only the parts still needed after the first frame are kept
  always_ff @(posedge clk) begin
    if (accept) begin
      lo_byte <= cmd_in[7:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      two_byte <= 1'b0;
    end else if (accept) begin
      two_byte <= cmd_in[CMD_RW_BIT];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= SEQ_IDLE;
    end else begin
      unique case (state)
        SEQ_IDLE: begin
          if (accept) begin
            state <= SEQ_HI;
          end
        end
        SEQ_HI: begin
          if (frame_done) begin
            state <= two_byte ? SEQ_LO : SEQ_IDLE;
          end
        end
        SEQ_LO: begin
          if (frame_done) begin
            state <= SEQ_IDLE;
          end
        end
        default: begin
          state <= SEQ_IDLE;
        end
      endcase
    end
  end

endmodule

// File: hdl/uart_rx_frame.sv
module uart_rx_frame (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 rx,
  output uart_cmd_pkg::byte_t  read_data,
  output logic                 read_rdy
);

  import uart_cmd_pkg::*;

  rx_state_t state;
  bit_idx_t  bit_idx;
  byte_t     shift;
  logic      par_q;
  logic      rx_meta;
  logic      rx_sync;
  logic      rx_prev;
  logic      fall;
  logic      run;
  logic      bit_end;
  logic      mid_bit;
  logic      frame_ok;

  // two flops for metastability, one more for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall = rx_prev && !rx_sync;
  assign run  = (state != RX_IDLE);

  baud_tick u_baud (
    .clk     (clk),
    .rst_n   (rst_n),
    .run     (run),
    .bit_end (bit_end),
    .mid_bit (mid_bit)
  );

  // odd parity over data and parity bit, stop must be high
  assign frame_ok = (^{shift, par_q}) && rx_sync;

  always_ff @(posedge clk) begin
    if (mid_bit && state == RX_DATA) begin
      shift <= {shift[6:0], rx_sync};
    end
    if (mid_bit && state == RX_PARITY) begin
      par_q <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= RX_IDLE;
      bit_idx   <= '0;
      read_data <= '0;
      read_rdy  <= 1'b0;
    end else begin
      read_rdy <= 1'b0;
      unique case (state)
        RX_IDLE: begin
          if (fall) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // start bit gone high again at mid-bit means a glitch
          if (mid_bit && rx_sync) begin
            state <= RX_IDLE;
          end else if (bit_end) begin
            state   <= RX_DATA;
            bit_idx <= '0;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            if (bit_idx == bit_idx_t'(7)) begin
              state <= RX_PARITY;
            end else begin
              bit_idx <= bit_idx + bit_idx_t'(1);
            end
          end
        end
        RX_PARITY: begin
          if (bit_end) begin
            state <= RX_STOP;
          end
        end
        RX_STOP: begin
          // leave at mid stop so the next start edge is not missed
          if (mid_bit) begin
            state <= RX_IDLE;
            if (frame_ok) begin
              read_data <= shift;
              read_rdy  <= 1'b1;
            end
          end
        end
        default: begin
          state <= RX_IDLE;
        end
      endcase
    end
  end

endmodule

// File: hdl/uart_cmd_port.sv
module uart_cmd_port (
  input  logic                 clk,
  input  logic                 rst_n,
  input  uart_cmd_pkg::cmd_t   cmd_in,
  input  logic                 cmd_vld,
  output logic                 cmd_rdy,
  output logic                 tx,
  input  logic                 rx,
  output uart_cmd_pkg::byte_t  read_data,
  output logic                 read_rdy
);

  import uart_cmd_pkg::*;

  byte_t frame_byte;
  logic  frame_start;
  logic  frame_done;

  // transmit path
  cmd_sequencer u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_in      (cmd_in),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .frame_byte  (frame_byte),
    .frame_start (frame_start),
    .frame_done  (frame_done)
  );

  uart_tx_frame u_tx (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_byte  (frame_byte),
    .frame_start (frame_start),
    .frame_done  (frame_done),
    .tx          (tx)
  );

  // receive path, independent of the transmitter
  uart_rx_frame u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

endmodule

// File: verification/tb_uart_cmd_port.sv
module tb_uart_cmd_port;

  import uart_cmd_pkg::*;

  localparam int WAIT_LIMIT    = 30 * CLKS_PER_BIT;
  localparam int NUM_RAND_CMDS = 3;
  localparam int NUM_RX_BYTES  = 4;

  logic  clk = 1'b0;
  logic  rst_n;
  cmd_t  cmd_in;
  logic  cmd_vld;
  logic  cmd_rdy;
  logic  tx;
  logic  rx;
  byte_t read_data;
  logic  read_rdy;

  int    rdy_count = 0;
  byte_t rdy_data  = '0;

  uart_cmd_port UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .rx        (rx),
    .read_data (read_data),
    .read_rdy  (read_rdy)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  // count receive strobes, keep the byte of the last one
  always @(negedge clk) begin
    if (read_rdy === 1'b1) begin
      rdy_count <= rdy_count + 1;
      rdy_data  <= read_data;
    end
  end

  // set when the data byte alone has an even number of ones
  function automatic logic odd_parity(input byte_t b);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        ones++;
      end
    end
    return (ones % 2 == 0);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "simulation stopped on the first problem");
  endtask

  task automatic check_equal(input string name, input int unsigned expected,
                             input int unsigned actual);
    assert (expected == actual) else begin
      abort_run($sformatf("error %s expected 0x%0h actual 0x%0h", name, expected, actual));
    end
  endtask

  task automatic wait_cmd_rdy(input string name);
    int cycles;
    cycles = 0;
    while (cmd_rdy !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run($sformatf("%s: cmd_rdy did not come back high in time", name));
      end
    end
  endtask

  task automatic issue_cmd(input cmd_t c);
    wait_cmd_rdy("issue_cmd");
    cmd_in  = c;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    check_equal("cmd_rdy after accept", 0, 32'(cmd_rdy));
    check_equal("tx start after accept", 0, 32'(tx));
  endtask

  // samples each bit in the middle of its period
  task automatic capture_tx_frame(output byte_t data, output logic par, output logic stop);
    int cycles;
    cycles = 0;
    data   = '0;
    while (tx !== 1'b0) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run("no start bit appeared on tx in time");
      end
    end
    repeat (HALF_BIT) @(negedge clk);
    check_equal("tx start bit", 0, 32'(tx));
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk);
      data = {data[6:0], tx};
      check_equal("cmd_rdy during frame", 0, 32'(cmd_rdy));
    end
    repeat (CLKS_PER_BIT) @(negedge clk);
    par = tx;
    repeat (CLKS_PER_BIT) @(negedge clk);
    stop = tx;
  endtask

  task automatic expect_tx_frame(input string name, input byte_t expected);
    byte_t data;
    logic  par;
    logic  stop;
    capture_tx_frame(data, par, stop);
    check_equal({name, " data"}, 32'(expected), 32'(data));
    check_equal({name, " parity"}, 32'(odd_parity(expected)), 32'(par));
    check_equal({name, " stop"}, 1, 32'(stop));
  endtask

  // tx must stay idle until the command is finished
  task automatic hold_idle_until_rdy(input string name);
    int cycles;
    cycles = 0;
    while (cmd_rdy !== 1'b1) begin
      check_equal({name, " idle tx"}, 1, 32'(tx));
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run($sformatf("%s: cmd_rdy did not rise after the last frame", name));
      end
    end
  endtask

  task automatic drive_rx_frame(input byte_t b, input logic good_par);
    logic par;
    par = odd_parity(b);
    if (!good_par) begin
      par = ~par;
    end
    rx = 1'b0;
    repeat (CLKS_PER_BIT) @(negedge clk);
    for (int i = 7; i >= 0; i--) begin
      rx = b[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
    rx = par;
    repeat (CLKS_PER_BIT) @(negedge clk);
    rx = 1'b1;
    repeat (CLKS_PER_BIT) @(negedge clk);
  endtask

  task automatic wait_rdy_count(input int target);
    int cycles;
    cycles = 0;
    while (rdy_count < target) begin
      @(negedge clk);
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        abort_run("read_rdy did not pulse after a good frame on rx");
      end
    end
  endtask

  initial begin
    cmd_t  cmd;
    byte_t rx_byte;
    byte_t held;
    int    base;

    void'($urandom(32'h19e6_0a2d));
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    repeat (8) begin
      @(negedge clk);
      check_equal("reset tx", 1, 32'(tx));
      check_equal("reset cmd_rdy", 1, 32'(cmd_rdy));
      check_equal("reset read_rdy", 0, 32'(read_rdy));
      check_equal("reset read_data", 0, 32'(read_data));
    end

    // one byte only when bit 15 is clear
    cmd = 16'($urandom) & 16'h7fff;
    issue_cmd(cmd);
    expect_tx_frame("single frame", cmd[15:8]);
    hold_idle_until_rdy("single frame");

    for (int n = 0; n < NUM_RAND_CMDS; n++) begin
      cmd = 16'($urandom) | 16'h8000;
      issue_cmd(cmd);
      expect_tx_frame("two frames hi", cmd[15:8]);
      expect_tx_frame("two frames lo", cmd[7:0]);
      hold_idle_until_rdy("two frames");
    end

    // a second valid while busy is dropped
    cmd = 16'($urandom) & 16'h7fff;
    issue_cmd(cmd);
    fork
      expect_tx_frame("ignored vld", cmd[15:8]);
      begin
        repeat (3 * CLKS_PER_BIT) @(negedge clk);
        cmd_in  = ~cmd | 16'h8000;
        cmd_vld = 1'b1;
        @(negedge clk);
        cmd_vld = 1'b0;
      end
    join
    hold_idle_until_rdy("ignored vld");
    repeat (2 * CLKS_PER_BIT) begin
      @(negedge clk);
      check_equal("ignored vld quiet tx", 1, 32'(tx));
      check_equal("ignored vld cmd_rdy", 1, 32'(cmd_rdy));
    end

    // receive while a command is being sent
    cmd = 16'($urandom) | 16'h8000;
    fork
      begin
        issue_cmd(cmd);
        expect_tx_frame("concurrent hi", cmd[15:8]);
        expect_tx_frame("concurrent lo", cmd[7:0]);
        hold_idle_until_rdy("concurrent");
      end
      begin
        for (int n = 0; n < NUM_RX_BYTES; n++) begin
          rx_byte = 8'($urandom);
          base    = rdy_count;
          drive_rx_frame(rx_byte, 1'b1);
          wait_rdy_count(base + 1);
          check_equal("rx strobe count", base + 1, rdy_count);
          check_equal("rx data", 32'(rx_byte), 32'(rdy_data));
        end
      end
    join

    // wrong parity, nothing may come out
    base    = rdy_count;
    held    = read_data;
    rx_byte = ~held;
    drive_rx_frame(rx_byte, 1'b0);
    repeat (CLKS_PER_BIT) @(negedge clk);
    check_equal("bad parity strobe count", base, rdy_count);
    check_equal("bad parity read_data", 32'(held), 32'(read_data));

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: verilog.f
hdl/uart_cmd_pkg.sv
hdl/baud_tick.sv
hdl/uart_tx_frame.sv
hdl/cmd_sequencer.sv
hdl/uart_rx_frame.sv
hdl/uart_cmd_port.sv
verification/tb_uart_cmd_port.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_uart_cmd_port
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the simulation output is searched for the pass message
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)" || { echo "simulation did not pass"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
